//--- rtl/la_csr_config.svh
`ifndef LA_CSR_CONFIG_SVH
`define LA_CSR_CONFIG_SVH

// widths
`define LA_XLEN        32
`define LA_CSR_ADDR_W  14
`define LA_CNT_W       64

// csr addresses
`define LA_CSR_CRMD    14'h0
`define LA_CSR_PRMD    14'h1
`define LA_CSR_ESTAT   14'h5
`define LA_CSR_ERA     14'h6
`define LA_CSR_BADV    14'h7
`define LA_CSR_EENTRY  14'hc
`define LA_CSR_SAVE0   14'h30
`define LA_CSR_SAVE1   14'h31
`define LA_CSR_SAVE2   14'h32
`define LA_CSR_SAVE3   14'h33
`define LA_CSR_TID     14'h40
`define LA_CSR_TCFG    14'h41
`define LA_CSR_TVAL    14'h42
`define LA_CSR_TICLR   14'h44

// exception codes
`define LA_ECODE_INT   6'h0
`define LA_ECODE_ADE   6'h8
`define LA_ECODE_ALE   6'h9
`define LA_ECODE_SYS   6'hb
`define LA_ECODE_BRK   6'hc
`define LA_ECODE_INE   6'hd
`define LA_ECODE_IPE   6'he
`define LA_ESUB_ADEM   9'd1

// rdcnt selectors
`define LA_RDCNT_CSR   2'd0
`define LA_RDCNT_ID    2'd1
`define LA_RDCNT_VLOW  2'd2
`define LA_RDCNT_VHIGH 2'd3

`endif

//--- rtl/la_csr_pkg.sv
`include "la_csr_config.svh"

package la_csr_pkg;

  typedef struct packed {
    logic                      we;
    logic [`LA_CSR_ADDR_W-1:0] addr;
    logic [`LA_XLEN-1:0]       mask;
    logic [`LA_XLEN-1:0]       data;
  } csr_wr_t;

  typedef struct packed {
    logic [`LA_CSR_ADDR_W-1:0] addr;
    logic [1:0]                rdcnt;
  } csr_rd_t;

  // one strobe per cause, intr is the interrupt cause
  typedef struct packed {
    logic intr;
    logic adef;
    logic adem;
    logic ale;
    logic sys;
    logic brk;
    logic ine;
    logic ipe;
  } excp_flags_t;

  typedef struct packed {
    logic                valid;
    logic [5:0]          ecode;
    logic [8:0]          esubcode;
    logic                va_err;
    logic [`LA_XLEN-1:0] badva;
    logic [`LA_XLEN-1:0] era;
  } excp_info_t;

  typedef struct packed {
    logic [`LA_XLEN-1:0] crmd;
    logic [`LA_XLEN-1:0] prmd;
    logic [`LA_XLEN-1:0] estat_low;
    logic [`LA_XLEN-1:0] era;
    logic [`LA_XLEN-1:0] badv;
    logic [`LA_XLEN-1:0] eentry;
    logic [`LA_XLEN-1:0] save0;
    logic [`LA_XLEN-1:0] save1;
    logic [`LA_XLEN-1:0] save2;
    logic [`LA_XLEN-1:0] save3;
    logic [`LA_XLEN-1:0] tid;
  } csr_state_t;

  typedef struct packed {
    logic [`LA_XLEN-1:0]  tcfg;
    logic [`LA_XLEN-1:0]  tval;
    logic                 ti;
    logic [`LA_CNT_W-1:0] cnt;
  } timer_state_t;

  typedef union packed {
    logic [`LA_XLEN-1:0] raw;
    struct packed {
      logic [`LA_XLEN-3:0] initval;
      logic                periodic;
      logic                en;
    } cfg;
  } tcfg_word_u;

endpackage

//--- rtl/exc_cause_encode.sv
`timescale 1ns/100ps
`include "la_csr_config.svh"

module exc_cause_encode import la_csr_pkg::*; (
  input  excp_flags_t         excp_i,
  input  logic [`LA_XLEN-1:0] pc_i,
  input  logic [`LA_XLEN-1:0] vaddr_i,
  output excp_info_t          info_o
);

  always_comb begin
    info_o.ecode    = `LA_ECODE_INT;
    info_o.esubcode = '0;
    // highest priority first
    if (excp_i.intr) begin
      info_o.ecode = `LA_ECODE_INT;
    end else if (excp_i.adef) begin
      info_o.ecode = `LA_ECODE_ADE;
    end else if (excp_i.adem) begin
      info_o.ecode    = `LA_ECODE_ADE;
      info_o.esubcode = `LA_ESUB_ADEM;
    end else if (excp_i.ale) begin
      info_o.ecode = `LA_ECODE_ALE;
    end else if (excp_i.sys) begin
      info_o.ecode = `LA_ECODE_SYS;
    end else if (excp_i.brk) begin
      info_o.ecode = `LA_ECODE_BRK;
    end else if (excp_i.ine) begin
      info_o.ecode = `LA_ECODE_INE;
    end else if (excp_i.ipe) begin
      info_o.ecode = `LA_ECODE_IPE;
    end
    info_o.valid  = |excp_i;
    info_o.va_err = excp_i.adef | excp_i.adem | excp_i.ale;
    // fetch faults report the pc itself
    info_o.badva  = excp_i.adef ? pc_i : vaddr_i;
    info_o.era    = pc_i;
  end

endmodule

//--- rtl/csr_regs.sv
`timescale 1ns/100ps
`include "la_csr_config.svh"

module csr_regs import la_csr_pkg::*; (
  input  logic       clk,
  input  logic       rst_n,
  input  csr_wr_t    wr_i,
  input  excp_info_t info_i,
  input  logic       ertn_i,
  input  logic [7:0] int_i,
  output csr_state_t state_o
);

  // writable bits
  localparam logic [`LA_XLEN-1:0] CRMD_WBITS   = 32'h0000_01ff;
  localparam logic [`LA_XLEN-1:0] PRMD_WBITS   = 32'h0000_0007;
  localparam logic [`LA_XLEN-1:0] ESTAT_WBITS  = 32'h0000_0003;
  localparam logic [`LA_XLEN-1:0] EENTRY_WBITS = 32'hffff_ffc0;

  logic [`LA_XLEN-1:0] crmd_q;
  logic [`LA_XLEN-1:0] prmd_q;
  logic [`LA_XLEN-1:0] estat_q;
  logic [`LA_XLEN-1:0] era_q;
  logic [`LA_XLEN-1:0] badv_q;
  logic [`LA_XLEN-1:0] eentry_q;
  logic [`LA_XLEN-1:0] tid_q;
  logic [`LA_XLEN-1:0] save_q [4];
  logic [`LA_XLEN-1:0] estat_wr;
  logic [3:0]          save_we;

  function automatic logic [`LA_XLEN-1:0] merge(input logic [`LA_XLEN-1:0] old_val,
                                               input logic [`LA_XLEN-1:0] wbits);
    logic [`LA_XLEN-1:0] sel;
    sel = wr_i.mask & wbits;
    return (old_val & ~sel) | (wr_i.data & sel);
  endfunction

  function automatic logic hit(input logic [`LA_CSR_ADDR_W-1:0] addr);
    return wr_i.we && (wr_i.addr == addr);
  endfunction

  assign estat_wr = merge(estat_q, ESTAT_WBITS);

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      save_we[i] = hit(`LA_CSR_SAVE0 + `LA_CSR_ADDR_W'(i));
    end
  end

  // a csr write in the same cycle overrides exception and ertn updates
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      crmd_q   <= 32'h0000_0008;
      prmd_q   <= '0;
      estat_q  <= '0;
      era_q    <= '0;
      badv_q   <= '0;
      eentry_q <= '0;
      tid_q    <= '0;
    end else begin
      if (hit(`LA_CSR_CRMD)) begin
        crmd_q <= merge(crmd_q, CRMD_WBITS);
      end else if (ertn_i) begin
        crmd_q[2:0] <= prmd_q[2:0];
      end else if (info_i.valid) begin
        crmd_q[2:0] <= 3'b000;
      end
      if (hit(`LA_CSR_PRMD)) begin
        prmd_q <= merge(prmd_q, PRMD_WBITS);
      end else if (info_i.valid) begin
        prmd_q[2:0] <= crmd_q[2:0];
      end
      // hw interrupt lines
      estat_q[9:2] <= int_i;
      if (info_i.valid) begin
        estat_q[21:16] <= info_i.ecode;
        estat_q[30:22] <= info_i.esubcode;
      end
      if (hit(`LA_CSR_ESTAT)) begin
        estat_q[1:0] <= estat_wr[1:0];
      end
      if (hit(`LA_CSR_ERA)) begin
        era_q <= merge(era_q, '1);
      end else if (info_i.valid) begin
        era_q <= info_i.era;
      end
      if (hit(`LA_CSR_BADV)) begin
        badv_q <= merge(badv_q, '1);
      end else if (info_i.valid && info_i.va_err) begin
        badv_q <= info_i.badva;
      end
      if (hit(`LA_CSR_EENTRY)) begin
        eentry_q <= merge(eentry_q, EENTRY_WBITS);
      end
      if (hit(`LA_CSR_TID)) begin
        tid_q <= merge(tid_q, '1);
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < 4; i++) begin
      if (!rst_n) begin
        save_q[i] <= '0;
      end else if (save_we[i]) begin
        save_q[i] <= merge(save_q[i], '1);
      end
    end
  end

  assign state_o.crmd      = crmd_q;
  assign state_o.prmd      = prmd_q;
  assign state_o.estat_low = estat_q;
  assign state_o.era       = era_q;
  assign state_o.badv      = badv_q;
  assign state_o.eentry    = eentry_q;
  assign state_o.save0     = save_q[0];
  assign state_o.save1     = save_q[1];
  assign state_o.save2     = save_q[2];
  assign state_o.save3     = save_q[3];
  assign state_o.tid       = tid_q;

endmodule

//--- rtl/csr_timer.sv
`timescale 1ns/100ps
`include "la_csr_config.svh"

module csr_timer import la_csr_pkg::*; (
  input  logic         clk,
  input  logic         rst_n,
  input  csr_wr_t      wr_i,
  output timer_state_t timer_o
);

  tcfg_word_u           wr_word;
  tcfg_word_u           tcfg_q;
  logic [`LA_XLEN-1:0]  tval_q;
  logic [`LA_CNT_W-1:0] cnt_q;
  logic                 timer_en_q;
  logic                 ti_q;
  logic                 tcfg_we;
  logic                 ticlr_we;
  logic                 expire;

  assign tcfg_we  = wr_i.we && (wr_i.addr == `LA_CSR_TCFG);
  assign ticlr_we = wr_i.we && (wr_i.addr == `LA_CSR_TICLR);

  // ticlr holds nothing, its old value is zero
  assign wr_word.raw = ((tcfg_we ? tcfg_q.raw : '0) & ~wr_i.mask) | (wr_i.data & wr_i.mask);

  assign expire = timer_en_q && (tval_q == '0) && !tcfg_we;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tcfg_q.raw <= '0;
      tval_q     <= '0;
      timer_en_q <= 1'b0;
      ti_q       <= 1'b0;
    end else begin
      if (tcfg_we) begin
        tcfg_q     <= wr_word;
        tval_q     <= {wr_word.cfg.initval, 2'b00};
        timer_en_q <= wr_word.cfg.en;
      end else if (timer_en_q) begin
        if (tval_q != '0) begin
          tval_q <= tval_q - `LA_XLEN'd1;
        end else if (tcfg_q.cfg.periodic) begin
          tval_q <= {tcfg_q.cfg.initval, 2'b00};
        end else begin
          // one-shot ends here
          tval_q     <= '1;
          timer_en_q <= 1'b0;
        end
      end
      // clear beats set
      if (ticlr_we && wr_word.raw[0]) begin
        ti_q <= 1'b0;
      end else if (expire) begin
        ti_q <= 1'b1;
      end
    end
  end

  // stable counter
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else begin
      cnt_q <= cnt_q + `LA_CNT_W'd1;
    end
  end

  assign timer_o.tcfg = tcfg_q.raw;
  assign timer_o.tval = tval_q;
  assign timer_o.ti   = ti_q;
  assign timer_o.cnt  = cnt_q;

endmodule

//--- rtl/csr_read_mux.sv
`timescale 1ns/100ps
`include "la_csr_config.svh"

module csr_read_mux import la_csr_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_rd_t             rd_i,
  input  csr_state_t          state_i,
  input  timer_state_t        timer_i,
  output logic [`LA_XLEN-1:0] r_data_o
);

  logic [`LA_XLEN-1:0] csr_word;
  logic [`LA_XLEN-1:0] rd_word;

  // unknown addresses and ticlr read as zero
  always_comb begin
    csr_word = '0;
    case (rd_i.addr)
      `LA_CSR_CRMD:   csr_word = state_i.crmd;
      `LA_CSR_PRMD:   csr_word = state_i.prmd;
      `LA_CSR_ESTAT:  csr_word = {state_i.estat_low[31:12], timer_i.ti,
                                  state_i.estat_low[10:0]};
      `LA_CSR_ERA:    csr_word = state_i.era;
      `LA_CSR_BADV:   csr_word = state_i.badv;
      `LA_CSR_EENTRY: csr_word = state_i.eentry;
      `LA_CSR_SAVE0:  csr_word = state_i.save0;
      `LA_CSR_SAVE1:  csr_word = state_i.save1;
      `LA_CSR_SAVE2:  csr_word = state_i.save2;
      `LA_CSR_SAVE3:  csr_word = state_i.save3;
      `LA_CSR_TID:    csr_word = state_i.tid;
      `LA_CSR_TCFG:   csr_word = timer_i.tcfg;
      `LA_CSR_TVAL:   csr_word = timer_i.tval;
      default:        csr_word = '0;
    endcase
  end

  always_comb begin
    case (rd_i.rdcnt)
      `LA_RDCNT_ID:    rd_word = state_i.tid;
      `LA_RDCNT_VLOW:  rd_word = timer_i.cnt[`LA_XLEN-1:0];
      `LA_RDCNT_VHIGH: rd_word = timer_i.cnt[`LA_CNT_W-1:`LA_XLEN];
      default:         rd_word = csr_word;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      r_data_o <= '0;
    end else begin
      r_data_o <= rd_word;
    end
  end

endmodule

//--- rtl/la_csr_top.sv
`timescale 1ns/100ps
`include "la_csr_config.svh"

module la_csr_top import la_csr_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  csr_wr_t             csr_wr_i,
  input  csr_rd_t             csr_rd_i,
  input  excp_flags_t         excp_i,
  input  logic [`LA_XLEN-1:0] pc_i,
  input  logic [`LA_XLEN-1:0] vaddr_i,
  input  logic                ertn_i,
  input  logic [7:0]          int_i,
  output logic [`LA_XLEN-1:0] csr_r_data_o,
  output csr_state_t          csr_o
);

  excp_info_t   excp_info;
  csr_state_t   csr_state;
  timer_state_t timer_state;

  exc_cause_encode i_encode (
    .excp_i  (excp_i),
    .pc_i    (pc_i),
    .vaddr_i (vaddr_i),
    .info_o  (excp_info)
  );

  csr_regs i_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (csr_wr_i),
    .info_i  (excp_info),
    .ertn_i  (ertn_i),
    .int_i   (int_i),
    .state_o (csr_state)
  );

  csr_timer i_timer (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_i    (csr_wr_i),
    .timer_o (timer_state)
  );

  csr_read_mux i_read_mux (
    .clk      (clk),
    .rst_n    (rst_n),
    .rd_i     (csr_rd_i),
    .state_i  (csr_state),
    .timer_i  (timer_state),
    .r_data_o (csr_r_data_o)
  );

  // timer interrupt shows as ESTAT bit 11
  always_comb begin
    csr_o               = csr_state;
    csr_o.estat_low[11] = timer_state.ti;
  end

endmodule

//--- sim/la_csr_sva.sv
`timescale 1ns/100ps
`include "la_csr_config.svh"

module la_csr_sva import la_csr_pkg::*; (
  input logic         clk,
  input logic         rst_n,
  input excp_flags_t  excp_i,
  input logic         ertn_i,
  input csr_state_t   csr_i,
  input timer_state_t timer_i
);

  // exception entry drops to kernel mode
  a_plv_cleared: assert property (@(posedge clk) disable iff (!rst_n)
    (|excp_i) |=> (csr_i.crmd[1:0] == 2'b00))
    else $error("crmd plv not zero after exception");

  a_ie_restored: assert property (@(posedge clk) disable iff (!rst_n)
    ertn_i |=> (csr_i.crmd[2] == $past(csr_i.prmd[2])))
    else $error("crmd ie not restored by ertn");

  a_ti_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(timer_i.ti) |-> timer_i.tcfg[0])
    else $error("timer interrupt raised with tcfg en clear");

endmodule

bind la_csr_top la_csr_sva i_sva (
  .clk     (clk),
  .rst_n   (rst_n),
  .excp_i  (excp_i),
  .ertn_i  (ertn_i),
  .csr_i   (csr_o),
  .timer_i (timer_state)
);

//--- sim/la_csr_tb.sv
`timescale 1ns/100ps
`include "la_csr_config.svh"

module la_csr_tb import la_csr_pkg::*; ();

  logic                clk;
  logic                rst_n;
  csr_wr_t             csr_wr;
  csr_rd_t             csr_rd;
  excp_flags_t         excp;
  logic [`LA_XLEN-1:0] pc;
  logic [`LA_XLEN-1:0] vaddr;
  logic                ertn;
  logic [7:0]          int_lines;
  logic [`LA_XLEN-1:0] r_data;
  csr_state_t          csr_st;

  // expected register state, kept from the csr rules
  csr_state_t          exp_st;
  integer              seed;

  la_csr_top i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .csr_wr_i     (csr_wr),
    .csr_rd_i     (csr_rd),
    .excp_i       (excp),
    .pc_i         (pc),
    .vaddr_i      (vaddr),
    .ertn_i       (ertn),
    .int_i        (int_lines),
    .csr_r_data_o (r_data),
    .csr_o        (csr_st)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  initial begin
    #200000;
    stop_run("simulation ran past its time limit");
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("Something failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_word(input string name, input logic [`LA_XLEN-1:0] exp,
                            input logic [`LA_XLEN-1:0] act);
    if (act !== exp) begin
      stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic check_state(input string name, input csr_state_t exp, input csr_state_t act);
    if (act !== exp) begin
      stop_run($sformatf("[FAIL] %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // word position inside csr_state_t, -1 for registers outside it
  function automatic int model_idx(input logic [`LA_CSR_ADDR_W-1:0] addr);
    case (addr)
      `LA_CSR_CRMD:   return 10;
      `LA_CSR_PRMD:   return 9;
      `LA_CSR_ESTAT:  return 8;
      `LA_CSR_ERA:    return 7;
      `LA_CSR_BADV:   return 6;
      `LA_CSR_EENTRY: return 5;
      `LA_CSR_SAVE0:  return 4;
      `LA_CSR_SAVE1:  return 3;
      `LA_CSR_SAVE2:  return 2;
      `LA_CSR_SAVE3:  return 1;
      `LA_CSR_TID:    return 0;
      default:        return -1;
    endcase
  endfunction

  task automatic do_read(input string name, input logic [`LA_CSR_ADDR_W-1:0] addr,
                         input logic [1:0] sel, input logic [`LA_XLEN-1:0] exp);
    csr_rd.addr  = addr;
    csr_rd.rdcnt = sel;
    next_cycle();
    check_word(name, exp, r_data);
  endtask

  // same-cycle read must still see the old value
  task automatic apply_write(input string name, input logic [`LA_CSR_ADDR_W-1:0] addr,
                             input logic [`LA_XLEN-1:0] mask, input logic [`LA_XLEN-1:0] data,
                             input logic [`LA_XLEN-1:0] wbits);
    int                  idx;
    logic [`LA_XLEN-1:0] old;
    logic [`LA_XLEN-1:0] sel;
    idx          = model_idx(addr);
    csr_wr.we    = 1'b1;
    csr_wr.addr  = addr;
    csr_wr.mask  = mask;
    csr_wr.data  = data;
    csr_rd.addr  = addr;
    csr_rd.rdcnt = `LA_RDCNT_CSR;
    next_cycle();
    csr_wr.we = 1'b0;
    if (idx >= 0) begin
      old = exp_st[idx*`LA_XLEN +: `LA_XLEN];
      check_word({name, " old value"}, old, r_data);
      sel = mask & wbits;
      exp_st[idx*`LA_XLEN +: `LA_XLEN] = (old & ~sel) | (data & sel);
    end
  endtask

  task automatic random_mask_write(input string name, input logic [`LA_CSR_ADDR_W-1:0] addr,
                                   input logic [`LA_XLEN-1:0] data,
                                   input logic [`LA_XLEN-1:0] wbits);
    logic [`LA_XLEN-1:0] mask;
    int                  idx;
    mask = $random(seed);
    idx  = model_idx(addr);
    if (idx < 0) begin
      stop_run($sformatf("%s uses csr %h which has no expected value", name, addr));
    end
    apply_write(name, addr, mask, data, wbits);
    do_read(name, addr, `LA_RDCNT_CSR, exp_st[idx*`LA_XLEN +: `LA_XLEN]);
  endtask

  task automatic take_exception(input string name, input excp_flags_t flags,
                                input logic [`LA_XLEN-1:0] pc_v,
                                input logic [`LA_XLEN-1:0] va_v);
    logic [5:0] codes [8];
    logic [5:0] ecode;
    logic [8:0] esub;
    // indexed by flag bit, ipe at bit 0
    codes = '{`LA_ECODE_IPE, `LA_ECODE_INE, `LA_ECODE_BRK, `LA_ECODE_SYS,
              `LA_ECODE_ALE, `LA_ECODE_ADE, `LA_ECODE_ADE, `LA_ECODE_INT};
    ecode = '0;
    esub  = '0;
    for (int b = 0; b < 8; b++) begin
      if (flags[b]) begin
        ecode = codes[b];
        esub  = (b == 5) ? `LA_ESUB_ADEM : 9'd0;
      end
    end
    excp  = flags;
    pc    = pc_v;
    vaddr = va_v;
    next_cycle();
    excp = '0;
    exp_st.prmd[2:0]        = exp_st.crmd[2:0];
    exp_st.crmd[2:0]        = 3'b000;
    exp_st.estat_low[21:16] = ecode;
    exp_st.estat_low[30:22] = esub;
    exp_st.era              = pc_v;
    if (flags.adef) begin
      exp_st.badv = pc_v;
    end else if (flags.adem || flags.ale) begin
      exp_st.badv = va_v;
    end
    check_state(name, exp_st, csr_st);
  endtask

  task automatic return_from_exception(input string name);
    ertn = 1'b1;
    next_cycle();
    ertn = 1'b0;
    exp_st.crmd[2:0] = exp_st.prmd[2:0];
    check_state(name, exp_st, csr_st);
  endtask

  // hw interrupt lines land in ESTAT bits 9:2 at the next edge
  task automatic check_int_lines(input string name, input logic [7:0] lines);
    int_lines = lines;
    next_cycle();
    exp_st.estat_low[9:2] = lines;
    check_state(name, exp_st, csr_st);
    do_read(name, `LA_CSR_ESTAT, `LA_RDCNT_CSR, exp_st.estat_low);
  endtask

  task automatic poll_until(input string name, input logic [`LA_CSR_ADDR_W-1:0] addr,
                            input logic [`LA_XLEN-1:0] mask, input logic [`LA_XLEN-1:0] value,
                            input int limit);
    int n;
    n            = 0;
    csr_rd.addr  = addr;
    csr_rd.rdcnt = `LA_RDCNT_CSR;
    next_cycle();
    while ((r_data & mask) !== value) begin
      n++;
      if (n > limit) begin
        stop_run($sformatf("%s timed out waiting on csr %h", name, addr));
      end
      next_cycle();
    end
  endtask

  task automatic check_counter_gap(input string name, input int k);
    logic [`LA_XLEN-1:0] first;
    int                  n;
    csr_rd.addr  = '0;
    csr_rd.rdcnt = `LA_RDCNT_VLOW;
    next_cycle();
    first = r_data;
    n     = 0;
    while (n < k) begin
      if (n > 1000) begin
        stop_run($sformatf("%s counter gap too long", name));
      end
      next_cycle();
      n++;
    end
    check_word(name, `LA_XLEN'(k), r_data - first);
  endtask

  initial begin
    int                  fd;
    int                  lineno;
    int                  cnt;
    string               line;
    string               name;
    logic [7:0]          op;
    logic [`LA_XLEN-1:0] a;
    logic [`LA_XLEN-1:0] b;
    logic [`LA_XLEN-1:0] c;
    logic [`LA_XLEN-1:0] d;
    rst_n     = 1'b0;
    csr_wr    = '0;
    csr_rd    = '0;
    excp      = '0;
    pc        = '0;
    vaddr     = '0;
    ertn      = 1'b0;
    int_lines = '0;
    seed      = 77923;
    exp_st      = '0;
    exp_st.crmd = 32'h0000_0008;
    lineno      = 0;
    repeat (8) @(posedge clk);
    #1;
    rst_n = 1'b1;
    fd = $fopen("sim/la_csr_vectors.txt", "r");
    if (fd == 0) begin
      stop_run("cannot open sim/la_csr_vectors.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      cnt  = $fgets(line, fd);
      lineno++;
      if (cnt > 1 && line[0] != "#") begin
        cnt = $sscanf(line, "%c %h %h %h %h", op, a, b, c, d);
        if (cnt != 5) begin
          stop_run($sformatf("vector line %0d is malformed", lineno));
        end
        name = $sformatf("line %0d op %c", lineno, op);
        case (op)
          "R": do_read(name, a[`LA_CSR_ADDR_W-1:0], b[1:0], c);
          "W": apply_write(name, a[`LA_CSR_ADDR_W-1:0], b, c, d);
          "M": random_mask_write(name, a[`LA_CSR_ADDR_W-1:0], c, d);
          "X": take_exception(name, a[7:0], b, c);
          "E": return_from_exception(name);
          "P": poll_until(name, a[`LA_CSR_ADDR_W-1:0], b, c, int'(d));
          "C": check_counter_gap(name, int'(a));
          default: stop_run($sformatf("vector line %0d has unknown operation", lineno));
        endcase
      end
    end
    $fclose(fd);
    check_int_lines("hw interrupt lines", 8'ha5);
    $display("Everything OK");
    $finish;
  end

endmodule

//--- la_csr.f
+incdir+rtl
rtl/la_csr_pkg.sv
rtl/exc_cause_encode.sv
rtl/csr_regs.sv
rtl/csr_timer.sv
rtl/csr_read_mux.sv
rtl/la_csr_top.sv
sim/la_csr_sva.sv
sim/la_csr_tb.sv

//--- Makefile
TOP = la_csr_tb

all: run

build:
	verilator --binary --timing --assert -f la_csr.f --top-module $(TOP) -o $(TOP)

run: build
	./obj_dir/$(TOP) > sim.log 2>&1; status=$$?; cat sim.log; \
	if [ $$status -ne 0 ] || grep -q "Something failed" sim.log; then exit 1; fi

lint:
	verilator --lint-only -Wall --timing -f la_csr.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

//--- sim/la_csr_vectors.txt
# op a b c d, all hex; R addr rdcnt expected -, W addr mask data wbits, M addr - data wbits
# X flags pc vaddr -, E - - - -, P addr mask value timeout, C cycles - - -
R 0 0 00000008 0
R 30 0 00000000 0
R 5 0 00000000 0
R 42 0 00000000 0
W 30 ffffffff 12345678 ffffffff
W 30 0000ffff abcdabcd ffffffff
R 30 0 1234abcd 0
M 31 0 5a5aa5a5 ffffffff
M 32 0 ffffffff ffffffff
M 33 0 c3c3c3c3 ffffffff
M c 0 ffffffff ffffffc0
M 0 0 ffffffff 000001ff
W 0 000001ff 0000000f 000001ff
R 0 0 0000000f 0
W 40 ffffffff 00000042 ffffffff
R 0 1 00000042 0
C 5 0 0 0
X 08 1c000100 00000000 0
R 1 0 00000007 0
R 5 0 000b0000 0
R 6 0 1c000100 0
R 0 0 00000008 0
E 0 0 0 0
R 0 0 0000000f 0
X 10 1c000200 00001234 0
R 7 0 00001234 0
X 50 1c000300 00005678 0
R 5 0 00080000 0
R 7 0 1c000300 0
W 41 ffffffff 0000000d 0
R 42 0 0000000c 0
R 42 0 0000000b 0
P 5 00000800 00000800 20
R 42 0 ffffffff 0
W 44 00000001 00000001 0
P 5 00000800 00000000 4
